/* src/mii_frame_pkg.sv */
// Shared bus map, register indices and control word; assumes a 15-bit byte address and 64-bit words
package mii_frame_pkg;

   localparam int BUS_ADDR_W = 15;
   localparam int BUS_DATA_W = 64;

   // Region bases, decoded from the upper address bits only
   localparam logic [BUS_ADDR_W-1:0] RX_BUF_BASE = 15'h4000;   // Bit 14 set
   localparam logic [BUS_ADDR_W-1:0] TX_BUF_BASE = 15'h1000;   // Bits 14..12 = 001
   localparam logic [BUS_ADDR_W-1:0] REG_BASE    = 15'h0800;   // Bits 14..11 = 0001

   // Register word indices from address bits 6..3
   localparam logic [3:0] REG_MAC_LO   = 4'd0;
   localparam logic [3:0] REG_CTRL     = 4'd1;
   localparam logic [3:0] REG_TX_LEN   = 4'd2;
   localparam logic [3:0] REG_STATUS   = 4'd6;   // Read side of word 6
   localparam logic [3:0] REG_FIRSTBUF = 4'd6;   // Write side of word 6
   localparam logic [3:0] REG_RX_LEN   = 4'd8;   // Lengths occupy 8 to 15

   localparam logic [47:0] DEFAULT_MAC = 48'h230100890702;

   localparam int PREAMBLE_NIBBLES = 15;
   localparam logic [3:0] NIB_PRE = 4'h5;   // Preamble nibble
   localparam logic [3:0] NIB_SFD = 4'hD;   // Delimiter nibble

   typedef struct packed {
      logic [39:0] rsvd_hi;
      logic        irq_en;
      logic        promiscuous;
      logic [3:0]  rsvd_mid;
      logic        loopback;
      logic        rsvd_lo;
      logic [15:0] mac_hi;   // MAC bits 47..32
   } ctrl_fields_t;

   // Control register word, seen either as the raw bus word or as fields
   typedef union packed {
      logic [BUS_DATA_W-1:0] raw;
      ctrl_fields_t          f;
   } ctrl_word_u;

endpackage

/* src/mii_frame_regs.sv */
// Register bank; word 6 status shows nextbuf only, and read data holds until the next read
module mii_frame_regs #(
   parameter int NUM_RX_BUF = 8,
   parameter int BUF_BYTES = 2048,
   localparam int PTR_W = $clog2(NUM_RX_BUF) + 1,
   localparam int LEN_W = $clog2(BUF_BYTES) + 1
) (
   input  logic                                clk_mii,
   input  logic                                rstn,
   input  logic                                i_bus_ce,
   input  logic                                i_bus_we,
   input  logic [mii_frame_pkg::BUS_ADDR_W-1:0] i_bus_addr,
   input  logic [mii_frame_pkg::BUS_DATA_W-1:0] i_bus_wdata,
   output logic [mii_frame_pkg::BUS_DATA_W-1:0] o_bus_rdata,
   input  logic                                i_tx_busy,
   input  logic [mii_frame_pkg::BUS_DATA_W-1:0] i_tx_buf_rdata,
   input  logic [mii_frame_pkg::BUS_DATA_W-1:0] i_rx_buf_rdata,
   input  logic                                i_rx_full,
   input  logic                                i_rx_avail,
   input  logic [PTR_W-1:0]                    i_rx_nextbuf,
   input  logic [LEN_W-1:0]                    i_rx_len,
   output logic [47:0]                         o_mac,
   output logic                                o_promiscuous,
   output logic                                o_loopback,
   output logic                                o_irq_en,
   output logic [PTR_W-1:0]                    o_firstbuf,
   output logic                                o_tx_start,
   output logic [LEN_W-1:0]                    o_tx_len
);
   import mii_frame_pkg::*;

   ctrl_word_u ctrl_wr;
   ctrl_word_u ctrl_rd;
   logic reg_sel;
   logic rd_q;   // Read issued last cycle
   logic [BUS_ADDR_W-1:0] addr_q;
   logic [BUS_DATA_W-1:0] rd_mux;
   logic [BUS_DATA_W-1:0] rdata_q;

   assign reg_sel = (i_bus_addr[14:11] == REG_BASE[14:11]);
   assign ctrl_wr.raw = i_bus_wdata;
   assign o_firstbuf = i_bus_wdata[PTR_W-1:0];   // Strobed into the ring by the top decode

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         o_mac <= DEFAULT_MAC;
         o_promiscuous <= 1'b0;
         o_loopback <= 1'b0;
         o_irq_en <= 1'b0;
         o_tx_len <= '0;
         o_tx_start <= 1'b0;
         rd_q <= 1'b0;
      end
      else
      begin
         o_tx_start <= 1'b0;
         rd_q <= i_bus_ce & ~i_bus_we;
         if (i_bus_ce && i_bus_we && reg_sel)
         begin
            case (i_bus_addr[6:3])
               REG_MAC_LO: o_mac[31:0] <= i_bus_wdata[31:0];
               REG_CTRL:
               begin
                  o_irq_en <= ctrl_wr.f.irq_en;
                  o_promiscuous <= ctrl_wr.f.promiscuous;
                  o_loopback <= ctrl_wr.f.loopback;
                  o_mac[47:32] <= ctrl_wr.f.mac_hi;
               end
               REG_TX_LEN:
               begin
                  o_tx_len <= i_bus_wdata[LEN_W-1:0];
                  o_tx_start <= 1'b1;   // Framer drops it while busy
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (i_bus_ce)
         addr_q <= i_bus_addr;
      if (rd_q)
         rdata_q <= rd_mux;   // Held for later cycles
   end

   always_comb
   begin
      ctrl_rd.raw = '0;
      ctrl_rd.f.irq_en = o_irq_en;
      ctrl_rd.f.promiscuous = o_promiscuous;
      ctrl_rd.f.loopback = o_loopback;
      ctrl_rd.f.mac_hi = o_mac[47:32];
      rd_mux = '0;
      if (addr_q[14] == RX_BUF_BASE[14])
         rd_mux = i_rx_buf_rdata;
      else if (addr_q[14:12] == TX_BUF_BASE[14:12])
         rd_mux = i_tx_buf_rdata;
      else if (addr_q[14:11] == REG_BASE[14:11])
      begin
         if (addr_q[6:3] >= REG_RX_LEN)
            rd_mux[LEN_W-1:0] = i_rx_len;   // Already selected by buffer index
         else
         begin
            case (addr_q[6:3])
               REG_MAC_LO: rd_mux[31:0] = o_mac[31:0];
               REG_CTRL:   rd_mux = ctrl_rd.raw;
               REG_TX_LEN:
               begin
                  rd_mux[31] = i_tx_busy;
                  rd_mux[LEN_W-1:0] = o_tx_len;
               end
               REG_STATUS:
               begin
                  rd_mux[PTR_W-1:0] = i_rx_nextbuf;
                  rd_mux[16] = i_rx_avail;
                  rd_mux[17] = i_rx_full;
               end
               default: ;
            endcase
         end
      end
   end

   assign o_bus_rdata = rd_q ? rd_mux : rdata_q;

endmodule

/* src/mii_tx_framer.sv */
// MII transmit framer without FCS or padding; lengths above BUF_BYTES are not supported
module mii_tx_framer #(
   parameter int BUF_BYTES = 2048,
   localparam int OFF_W = $clog2(BUF_BYTES),
   localparam int LEN_W = OFF_W + 1,
   localparam int WA_W = OFF_W - 3
) (
   input  logic                                clk_mii,
   input  logic                                rstn,
   input  logic                                i_buf_we,
   input  logic [WA_W-1:0]                     i_buf_addr,
   input  logic [mii_frame_pkg::BUS_DATA_W-1:0] i_buf_wdata,
   output logic [mii_frame_pkg::BUS_DATA_W-1:0] o_buf_rdata,
   input  logic                                i_tx_start,
   input  logic [LEN_W-1:0]                    i_tx_len,
   output logic                                o_tx_busy,
   output logic [3:0]                          o_etxd,
   output logic                                o_etx_en,
   output logic                                o_etx_er
);
   import mii_frame_pkg::*;

   localparam int CNT_W = LEN_W + 1;

   logic [BUS_DATA_W-1:0] mem [2**WA_W];
   logic [LEN_W-1:0] len_q;
   logic [CNT_W-1:0] nib_cnt;   // Nibble slot, preamble included
   logic [CNT_W-1:0] pay;       // Payload nibble index
   logic [BUS_DATA_W-1:0] tx_word;
   logic [7:0] tx_byte;
   logic [3:0] nib;
   logic last;

   always_ff @(posedge clk_mii)
   begin
      if (i_buf_we)
         mem[i_buf_addr] <= i_buf_wdata;
      o_buf_rdata <= mem[i_buf_addr];
   end

   assign pay = nib_cnt - CNT_W'(PREAMBLE_NIBBLES + 1);
   assign tx_word = mem[pay[OFF_W:4]];
   assign tx_byte = tx_word[{pay[3:1], 3'b000} +: 8];
   assign last = (nib_cnt == CNT_W'(PREAMBLE_NIBBLES) + {len_q, 1'b0});

   always_comb
   begin
      if (nib_cnt < CNT_W'(PREAMBLE_NIBBLES))
         nib = NIB_PRE;
      else if (nib_cnt == CNT_W'(PREAMBLE_NIBBLES))
         nib = NIB_SFD;
      else
         nib = pay[0] ? tx_byte[7:4] : tx_byte[3:0];   // Low nibble first
   end

   always_ff @(posedge clk_mii)
   begin
      if (!o_tx_busy && i_tx_start)
         len_q <= i_tx_len;
   end

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         o_tx_busy <= 1'b0;
         nib_cnt <= '0;
         o_etx_en <= 1'b0;
         o_etxd <= 4'h0;
      end
      else
      begin
         o_etx_en <= o_tx_busy;   // One slot behind the sequencer
         o_etxd <= o_tx_busy ? nib : 4'h0;
         if (o_tx_busy)
         begin
            nib_cnt <= nib_cnt + 1'b1;
            if (last)
               o_tx_busy <= 1'b0;
         end
         else if (i_tx_start)
         begin
            o_tx_busy <= 1'b1;
            nib_cnt <= '0;
         end
      end
   end

   assign o_etx_er = 1'b0;

endmodule

/* src/mii_rx_deframer.sv */
// MII receive deframer; any 5 nibble before D starts a frame and an errored frame reports zero bytes
module mii_rx_deframer #(
   parameter int BUF_BYTES = 2048,
   localparam int LEN_W = $clog2(BUF_BYTES) + 1
) (
   input  logic             clk_mii,
   input  logic             rstn,
   input  logic [3:0]       i_rxd,
   input  logic             i_rx_dv,
   input  logic             i_rx_er,
   output logic             o_byte_valid,
   output logic [7:0]       o_byte_data,
   output logic [LEN_W-1:0] o_byte_index,
   output logic             o_frame_end,
   output logic [LEN_W-1:0] o_frame_bytes,
   output logic [47:0]      o_dest_mac
);
   import mii_frame_pkg::*;

   logic dv_q;
   logic pre_seen;   // Last nibble was preamble
   logic in_data;
   logic hi_half;
   logic err;
   logic [3:0] low_nib;
   logic [LEN_W-1:0] byte_cnt;

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         dv_q <= 1'b0;
         pre_seen <= 1'b0;
         in_data <= 1'b0;
         hi_half <= 1'b0;
         err <= 1'b0;
         byte_cnt <= '0;
         o_byte_valid <= 1'b0;
         o_frame_end <= 1'b0;
      end
      else
      begin
         dv_q <= i_rx_dv;
         o_byte_valid <= 1'b0;
         o_frame_end <= 1'b0;
         if (i_rx_dv && !in_data)
         begin
            pre_seen <= (i_rxd == NIB_PRE);
            if (pre_seen && i_rxd == NIB_SFD)
            begin
               in_data <= 1'b1;
               hi_half <= 1'b0;
               byte_cnt <= '0;
               err <= i_rx_er;
            end
         end
         else if (i_rx_dv)
         begin
            err <= err | i_rx_er;
            hi_half <= ~hi_half;
            if (!hi_half)
               low_nib <= i_rxd;
            else
            begin
               o_byte_valid <= 1'b1;
               o_byte_data <= {i_rxd, low_nib};
               o_byte_index <= byte_cnt;
               byte_cnt <= byte_cnt + 1'b1;
               if (byte_cnt < LEN_W'(6))
                  o_dest_mac <= {o_dest_mac[39:0], i_rxd, low_nib};   // First byte ends on top
            end
         end
         else
         begin
            pre_seen <= 1'b0;
            in_data <= 1'b0;
            if (dv_q)
            begin
               o_frame_end <= 1'b1;
               o_frame_bytes <= (err || !in_data) ? '0 : byte_cnt;   // No delimiter also counts as empty
            end
         end
      end
   end

endmodule

/* src/mii_rx_buffers.sv */
// Receive ring for up to 8 buffers; firstbuf must not pass nextbuf, and bytes past BUF_BYTES wrap
module mii_rx_buffers #(
   parameter int NUM_RX_BUF = 8,
   parameter int BUF_BYTES = 2048,
   parameter int MIN_FRAME_BYTES = 14,
   localparam int IDX_W = $clog2(NUM_RX_BUF),
   localparam int PTR_W = IDX_W + 1,
   localparam int OFF_W = $clog2(BUF_BYTES),
   localparam int LEN_W = OFF_W + 1,
   localparam int WA_W = IDX_W + OFF_W - 3
) (
   input  logic                                clk_mii,
   input  logic                                rstn,
   input  logic                                i_byte_valid,
   input  logic [7:0]                          i_byte_data,
   input  logic [LEN_W-1:0]                    i_byte_index,
   input  logic                                i_frame_end,
   input  logic [LEN_W-1:0]                    i_frame_bytes,
   input  logic [47:0]                         i_dest_mac,
   input  logic [47:0]                         i_mac,
   input  logic                                i_promiscuous,
   input  logic                                i_irq_en,
   input  logic                                i_firstbuf_we,
   input  logic [PTR_W-1:0]                    i_firstbuf,
   input  logic                                i_bus_re,
   input  logic [mii_frame_pkg::BUS_ADDR_W-1:0] i_bus_addr,
   output logic [mii_frame_pkg::BUS_DATA_W-1:0] o_bus_rdata,
   output logic                                o_full,
   output logic                                o_avail,
   output logic [PTR_W-1:0]                    o_nextbuf,
   output logic [LEN_W-1:0]                    o_rx_len,
   output logic                                o_eth_irq
);
   import mii_frame_pkg::*;

   logic [BUS_DATA_W-1:0] mem [2**WA_W];
   logic [LEN_W-1:0] len_mem [NUM_RX_BUF];
   logic [PTR_W-1:0] firstbuf;
   logic [PTR_W-1:0] used;
   logic [WA_W-1:0] wr_addr;
   logic credit;
   logic dest_ok;
   logic commit;   // Frame passes length and filter

   assign used = o_nextbuf - firstbuf;
   assign credit = (used < PTR_W'(NUM_RX_BUF));
   assign o_avail = (o_nextbuf != firstbuf);
   assign dest_ok = (i_dest_mac == i_mac) | (&i_dest_mac) |
                    (i_dest_mac[47:24] == 24'h01005E) | i_promiscuous;
   assign commit = i_frame_end & dest_ok & (i_frame_bytes >= LEN_W'(MIN_FRAME_BYTES));
   assign wr_addr = {o_nextbuf[IDX_W-1:0], i_byte_index[OFF_W-1:3]};

   always_ff @(posedge clk_mii)
   begin
      if (!rstn)
      begin
         o_nextbuf <= '0;
         firstbuf <= '0;
         o_full <= 1'b0;
         o_eth_irq <= 1'b0;
      end
      else
      begin
         o_eth_irq <= o_avail & i_irq_en;
         if (i_firstbuf_we)
            firstbuf <= i_firstbuf;   // Hands credits back
         if (commit)
         begin
            if (credit)
            begin
               o_nextbuf <= o_nextbuf + 1'b1;
               o_full <= 1'b0;
            end
            else
               o_full <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_mii)
   begin
      if (commit && credit)
         len_mem[o_nextbuf[IDX_W-1:0]] <= i_frame_bytes;
      o_rx_len <= len_mem[i_bus_addr[3 +: IDX_W]];
   end

   // Bytes land in the slot at nextbuf only while a credit is free
   always_ff @(posedge clk_mii)
   begin
      if (i_byte_valid && credit)
         mem[wr_addr][{i_byte_index[2:0], 3'b000} +: 8] <= i_byte_data;
      if (i_bus_re)
         o_bus_rdata <= mem[i_bus_addr[3 +: WA_W]];
   end

endmodule

/* src/mii_framing_top.sv */
// MII framing top on one clock; NUM_RX_BUF and BUF_BYTES must be powers of two, NUM_RX_BUF 2 to 8
module mii_framing_top #(
   parameter int NUM_RX_BUF = 8,
   parameter int BUF_BYTES = 2048,
   parameter int MIN_FRAME_BYTES = 14
) (
   input  logic                                clk_mii,
   input  logic                                rstn,
   input  logic                                i_bus_ce,
   input  logic                                i_bus_we,
   input  logic [mii_frame_pkg::BUS_ADDR_W-1:0] i_bus_addr,
   input  logic [mii_frame_pkg::BUS_DATA_W-1:0] i_bus_wdata,
   output logic [mii_frame_pkg::BUS_DATA_W-1:0] o_bus_rdata,
   input  logic [3:0]                          i_erxd,
   input  logic                                i_erx_dv,
   input  logic                                i_erx_er,
   output logic [3:0]                          o_etxd,
   output logic                                o_etx_en,
   output logic                                o_etx_er,
   output logic                                o_eth_irq
);
   import mii_frame_pkg::*;

   localparam int PTR_W = $clog2(NUM_RX_BUF) + 1;
   localparam int LEN_W = $clog2(BUF_BYTES) + 1;

   logic [47:0] mac, dest_mac;
   logic promiscuous, loopback, irq_en;
   logic [PTR_W-1:0] firstbuf, nextbuf;
   logic tx_start, tx_busy, tx_buf_we, rx_bus_re, firstbuf_we;
   logic [LEN_W-1:0] tx_len, rx_len, byte_index, frame_bytes;
   logic [BUS_DATA_W-1:0] tx_buf_rdata, rx_buf_rdata;
   logic rx_full, rx_avail, byte_valid, frame_end;
   logic [7:0] byte_data;
   logic [3:0] rxd;
   logic rx_dv, rx_er;

   // Buffer strobes go straight to the memories
   assign tx_buf_we = i_bus_ce & i_bus_we & (i_bus_addr[14:12] == TX_BUF_BASE[14:12]);
   assign rx_bus_re = i_bus_ce & ~i_bus_we & (i_bus_addr[14] == RX_BUF_BASE[14]);
   assign firstbuf_we = i_bus_ce & i_bus_we & (i_bus_addr[14:11] == REG_BASE[14:11]) &
                        (i_bus_addr[6:3] == REG_FIRSTBUF);

   assign rxd = loopback ? o_etxd : i_erxd;   // Loopback takes the transmit pins
   assign rx_dv = loopback ? o_etx_en : i_erx_dv;
   assign rx_er = loopback ? o_etx_er : i_erx_er;

   mii_frame_regs #(.NUM_RX_BUF(NUM_RX_BUF), .BUF_BYTES(BUF_BYTES)) i_mii_frame_regs (
      .clk_mii(clk_mii), .rstn(rstn),
      .i_bus_ce(i_bus_ce), .i_bus_we(i_bus_we),
      .i_bus_addr(i_bus_addr), .i_bus_wdata(i_bus_wdata), .o_bus_rdata(o_bus_rdata),
      .i_tx_busy(tx_busy), .i_tx_buf_rdata(tx_buf_rdata), .i_rx_buf_rdata(rx_buf_rdata),
      .i_rx_full(rx_full), .i_rx_avail(rx_avail), .i_rx_nextbuf(nextbuf), .i_rx_len(rx_len),
      .o_mac(mac), .o_promiscuous(promiscuous), .o_loopback(loopback), .o_irq_en(irq_en),
      .o_firstbuf(firstbuf), .o_tx_start(tx_start), .o_tx_len(tx_len)
   );

   mii_tx_framer #(.BUF_BYTES(BUF_BYTES)) i_mii_tx_framer (
      .clk_mii(clk_mii), .rstn(rstn),
      .i_buf_we(tx_buf_we), .i_buf_addr(i_bus_addr[3 +: LEN_W - 4]),
      .i_buf_wdata(i_bus_wdata), .o_buf_rdata(tx_buf_rdata),
      .i_tx_start(tx_start), .i_tx_len(tx_len), .o_tx_busy(tx_busy),
      .o_etxd(o_etxd), .o_etx_en(o_etx_en), .o_etx_er(o_etx_er)
   );

   mii_rx_deframer #(.BUF_BYTES(BUF_BYTES)) i_mii_rx_deframer (
      .clk_mii(clk_mii), .rstn(rstn),
      .i_rxd(rxd), .i_rx_dv(rx_dv), .i_rx_er(rx_er),
      .o_byte_valid(byte_valid), .o_byte_data(byte_data), .o_byte_index(byte_index),
      .o_frame_end(frame_end), .o_frame_bytes(frame_bytes), .o_dest_mac(dest_mac)
   );

   mii_rx_buffers #(
      .NUM_RX_BUF(NUM_RX_BUF), .BUF_BYTES(BUF_BYTES), .MIN_FRAME_BYTES(MIN_FRAME_BYTES)
   ) i_mii_rx_buffers (
      .clk_mii(clk_mii), .rstn(rstn),
      .i_byte_valid(byte_valid), .i_byte_data(byte_data), .i_byte_index(byte_index),
      .i_frame_end(frame_end), .i_frame_bytes(frame_bytes), .i_dest_mac(dest_mac),
      .i_mac(mac), .i_promiscuous(promiscuous), .i_irq_en(irq_en),
      .i_firstbuf_we(firstbuf_we), .i_firstbuf(firstbuf),
      .i_bus_re(rx_bus_re), .i_bus_addr(i_bus_addr), .o_bus_rdata(rx_buf_rdata),
      .o_full(rx_full), .o_avail(rx_avail), .o_nextbuf(nextbuf),
      .o_rx_len(rx_len), .o_eth_irq(o_eth_irq)
   );

endmodule

/* tb/tb_mii_framing.sv */
// Testbench for the default parameters only (8 buffers of 2048 bytes); needs concurrent SVA support
module tb_mii_framing;
   timeunit 1ns;
   timeprecision 100ps;
   import mii_frame_pkg::*;

   localparam int NUM_RX_BUF = 8;
   localparam int BUF_BYTES = 2048;
   localparam int MIN_FRAME_BYTES = 14;
   localparam int CLK_NS = 4;
   localparam int FRAME_CYCLES = 625;   // 64-byte frame plus bus setup, with wide margin
   localparam int WATCHDOG_NS = 5 * 16 * FRAME_CYCLES * CLK_NS;   // Five tests of 16 frames
   localparam int WAIT_LIMIT = 400;
   localparam logic [31:0] SEED = 32'h4e3f;

   logic clk_mii = 1'b0;
   logic rstn;
   logic i_bus_ce;
   logic i_bus_we;
   logic [BUS_ADDR_W-1:0] i_bus_addr;
   logic [BUS_DATA_W-1:0] i_bus_wdata;
   logic [BUS_DATA_W-1:0] o_bus_rdata;
   logic [3:0] i_erxd;
   logic i_erx_dv;
   logic i_erx_er;
   logic [3:0] o_etxd;
   logic o_etx_en;
   logic o_etx_er;
   logic o_eth_irq;

   int errors = 0;
   int checks = 0;
   int test_errs = 0;
   logic [7:0] frame_q[$];   // Frame under test, destination first
   logic [3:0] exp_next;     // Model of the nextbuf pointer
   logic [3:0] exp_first;
   logic [63:0] rd;

   always #(CLK_NS / 2) clk_mii = ~clk_mii;

   mii_framing_top #(
      .NUM_RX_BUF(NUM_RX_BUF), .BUF_BYTES(BUF_BYTES), .MIN_FRAME_BYTES(MIN_FRAME_BYTES)
   ) i_mii_framing_top (
      .clk_mii(clk_mii), .rstn(rstn),
      .i_bus_ce(i_bus_ce), .i_bus_we(i_bus_we), .i_bus_addr(i_bus_addr),
      .i_bus_wdata(i_bus_wdata), .o_bus_rdata(o_bus_rdata),
      .i_erxd(i_erxd), .i_erx_dv(i_erx_dv), .i_erx_er(i_erx_er),
      .o_etxd(o_etxd), .o_etx_en(o_etx_en), .o_etx_er(o_etx_er), .o_eth_irq(o_eth_irq)
   );

   preamble_first: assert property (@(posedge clk_mii) disable iff (!rstn)
      $rose(o_etx_en) |-> (o_etxd == 4'h5))
   else
   begin
      errors++;
      $display("MISMATCH at %0t ns: burst did not open with a preamble nibble", $time);
   end

   no_tx_error: assert property (@(posedge clk_mii) disable iff (!rstn) !o_etx_er)
   else
   begin
      errors++;
      $display("MISMATCH at %0t ns: o_etx_er went high", $time);
   end

   task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
      end
   endtask

   function automatic logic [BUS_ADDR_W-1:0] reg_addr(input logic [3:0] idx);
      return REG_BASE | BUS_ADDR_W'({idx, 3'b000});
   endfunction

   function automatic logic [63:0] ctrl_word(input logic irq, input logic prom, input logic loop);
      ctrl_word_u c;
      c.raw = '0;
      c.f.irq_en = irq;
      c.f.promiscuous = prom;
      c.f.loopback = loop;
      c.f.mac_hi = DEFAULT_MAC[47:32];   // MAC is never changed here
      return c.raw;
   endfunction

   function automatic logic [63:0] status_word(input logic full, input logic avail,
                                               input logic [3:0] next);
      logic [63:0] w;
      w = '0;
      w[3:0] = next;
      w[16] = avail;
      w[17] = full;
      return w;
   endfunction

   // Bus tasks start and end on a falling edge
   task automatic bus_write(input logic [BUS_ADDR_W-1:0] addr, input logic [63:0] data);
      i_bus_ce = 1'b1;
      i_bus_we = 1'b1;
      i_bus_addr = addr;
      i_bus_wdata = data;
      @(negedge clk_mii);
      i_bus_ce = 1'b0;
      i_bus_we = 1'b0;
   endtask

   task automatic bus_read(input logic [BUS_ADDR_W-1:0] addr, output logic [63:0] data);
      i_bus_ce = 1'b1;
      i_bus_we = 1'b0;
      i_bus_addr = addr;
      @(negedge clk_mii);
      i_bus_ce = 1'b0;
      data = o_bus_rdata;   // One cycle after the request
   endtask

   task automatic build_frame(input logic [47:0] dest, input int len);
      frame_q.delete();
      for (int k = 0; k < len; k++)
      begin
         if (k < 6)
            frame_q.push_back(dest[47 - 8 * k -: 8]);
         else
            frame_q.push_back(8'($urandom));
      end
   endtask

   task automatic drive_nibble(input logic [3:0] nib);
      i_erx_dv = 1'b1;
      i_erxd = nib;
      @(negedge clk_mii);
   endtask

   task automatic drive_mii_frame;
      for (int n = 0; n < PREAMBLE_NIBBLES; n++)
         drive_nibble(4'h5);
      drive_nibble(4'hD);
      foreach (frame_q[k])
      begin
         drive_nibble(frame_q[k][3:0]);   // Low nibble first
         drive_nibble(frame_q[k][7:4]);
      end
      i_erx_dv = 1'b0;
      i_erxd = 4'h0;
   endtask

   // frame_end and the commit follow dv by two cycles
   task automatic settle;
      repeat (4) @(negedge clk_mii);
   endtask

   task automatic collect_tx_frame;
      logic [3:0] nibs[$];
      logic [3:0] exp_nib;
      int waited;
      int exp_len;
      int k;
      waited = 0;
      exp_len = PREAMBLE_NIBBLES + 1 + 2 * frame_q.size();
      while (!o_etx_en && waited < WAIT_LIMIT)
      begin
         @(negedge clk_mii);
         waited++;
      end
      if (waited >= WAIT_LIMIT)
      begin
         errors++;
         $display("Timeout at %0t ns: o_etx_en never rose", $time);
      end
      while (o_etx_en && nibs.size() < 2 * exp_len)
      begin
         nibs.push_back(o_etxd);
         @(negedge clk_mii);
      end
      check_value(nibs.size(), exp_len, "o_etx_en high cycles");
      for (int n = 0; n < nibs.size() && n < exp_len; n++)
      begin
         k = (n - PREAMBLE_NIBBLES - 1) / 2;
         if (n < PREAMBLE_NIBBLES)
            exp_nib = 4'h5;
         else if (n == PREAMBLE_NIBBLES)
            exp_nib = 4'hD;
         else
            exp_nib = ((n - PREAMBLE_NIBBLES - 1) % 2) ? frame_q[k][7:4] : frame_q[k][3:0];
         check_value(nibs[n], exp_nib, $sformatf("tx nibble %0d", n));
      end
   endtask

   task automatic transmit_frame;
      for (int w = 0; w < (frame_q.size() + 7) / 8; w++)
      begin
         rd = '0;
         for (int b = 0; b < 8; b++)
            if (8 * w + b < frame_q.size())
               rd[8 * b +: 8] = frame_q[8 * w + b];
         bus_write(TX_BUF_BASE + BUS_ADDR_W'(8 * w), rd);
      end
      bus_write(reg_addr(REG_TX_LEN), 64'(frame_q.size()));
      collect_tx_frame();
   endtask

   task automatic check_rx_frame(input logic [3:0] ptr);
      int idx;
      logic [63:0] word;
      idx = ptr % NUM_RX_BUF;
      bus_read(reg_addr(REG_RX_LEN + 4'(idx)), word);
      check_value(word, 64'(frame_q.size()), $sformatf("rx length of buffer %0d", idx));
      for (int w = 0; w < (frame_q.size() + 7) / 8; w++)
      begin
         bus_read(RX_BUF_BASE + BUS_ADDR_W'(idx * BUF_BYTES + 8 * w), word);
         for (int b = 0; b < 8; b++)
            if (8 * w + b < frame_q.size())
               check_value(word[8 * b +: 8], frame_q[8 * w + b],
                           $sformatf("rx buffer %0d byte %0d", idx, 8 * w + b));
      end
   endtask

   task automatic wait_irq(input logic level);
      int waited;
      waited = 0;
      while (o_eth_irq !== level && waited < WAIT_LIMIT)
      begin
         @(negedge clk_mii);
         waited++;
      end
      checks++;
      if (o_eth_irq !== level)
      begin
         errors++;
         $display("Timeout at %0t ns: o_eth_irq did not go %0s", $time, level ? "high" : "low");
      end
   endtask

   task automatic finish_test(input string name);
      if (errors == test_errs)
         $display("%s: ok", name);
      else
         $display("%s: %0d errors", name, errors - test_errs);
      test_errs = errors;
   endtask

   initial
   begin
      void'($urandom(SEED));
      rstn = 1'b0;
      i_bus_ce = 1'b0;
      i_bus_we = 1'b0;
      i_bus_addr = '0;
      i_bus_wdata = '0;
      i_erxd = 4'h0;
      i_erx_dv = 1'b0;
      i_erx_er = 1'b0;
      exp_next = '0;
      repeat (2) @(negedge clk_mii);
      rstn = 1'b1;

      check_value(o_etx_en, 1'b0, "o_etx_en after reset");
      check_value(o_eth_irq, 1'b0, "o_eth_irq after reset");
      bus_read(reg_addr(REG_STATUS), rd);
      check_value(rd, status_word(1'b0, 1'b0, 4'd0), "status after reset");
      bus_read(reg_addr(REG_MAC_LO), rd);
      check_value(rd, {32'h0, DEFAULT_MAC[31:0]}, "MAC low after reset");
      bus_read(reg_addr(REG_CTRL), rd);
      check_value(rd, ctrl_word(1'b0, 1'b0, 1'b0), "control after reset");
      finish_test("reset defaults");

      build_frame(48'h0A1B2C3D4E5F, 37);
      transmit_frame();
      bus_read(reg_addr(REG_TX_LEN), rd);
      check_value(rd, 64'd37, "tx length with busy clear");
      finish_test("transmit");

      bus_write(reg_addr(REG_CTRL), ctrl_word(1'b1, 1'b0, 1'b0));
      build_frame(DEFAULT_MAC, 50);
      drive_mii_frame();
      wait_irq(1'b1);
      bus_read(reg_addr(REG_STATUS), rd);
      check_value(rd, status_word(1'b0, 1'b1, exp_next + 1'b1), "status after rx frame");
      check_rx_frame(exp_next);
      exp_next++;
      bus_write(reg_addr(REG_FIRSTBUF), 64'(exp_next));   // Hand the buffer back
      wait_irq(1'b0);
      finish_test("external receive");

      bus_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b0, 1'b1));
      build_frame(48'h02AABBCCDDEE, 30);
      transmit_frame();
      settle();
      bus_read(reg_addr(REG_STATUS), rd);
      check_value(rd, status_word(1'b0, 1'b0, exp_next), "foreign frame dropped");
      bus_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b1, 1'b1));
      transmit_frame();
      settle();
      bus_read(reg_addr(REG_STATUS), rd);
      check_value(rd, status_word(1'b0, 1'b1, exp_next + 1'b1), "promiscuous frame kept");
      check_rx_frame(exp_next);
      exp_next++;
      bus_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b0, 1'b1));
      build_frame(48'hFFFFFFFFFFFF, 24);
      transmit_frame();
      settle();
      check_rx_frame(exp_next);
      exp_next++;
      build_frame(48'h01005E000001, 20);   // Multicast prefix
      transmit_frame();
      settle();
      check_rx_frame(exp_next);
      exp_next++;
      bus_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b1, 1'b1));
      build_frame(48'hFFFFFFFFFFFF, MIN_FRAME_BYTES - 1);
      transmit_frame();
      settle();
      bus_read(reg_addr(REG_STATUS), rd);
      check_value(rd, status_word(1'b0, 1'b1, exp_next), "short frame dropped");
      bus_write(reg_addr(REG_FIRSTBUF), 64'(exp_next));
      bus_write(reg_addr(REG_CTRL), ctrl_word(1'b0, 1'b0, 1'b0));
      finish_test("loopback filtering");

      exp_first = exp_next;
      for (int i = 0; i < NUM_RX_BUF; i++)
      begin
         build_frame(DEFAULT_MAC, 20 + i);
         drive_mii_frame();
         settle();
         check_rx_frame(exp_next);
         exp_next++;
      end
      bus_read(reg_addr(REG_STATUS), rd);
      check_value(rd, status_word(1'b0, 1'b1, exp_next), "ring filled");
      build_frame(DEFAULT_MAC, 40);
      drive_mii_frame();
      settle();
      bus_read(reg_addr(REG_STATUS), rd);
      check_value(rd, status_word(1'b1, 1'b1, exp_next), "frame without credit");
      bus_write(reg_addr(REG_FIRSTBUF), 64'(exp_first + 1'b1));   // One credit back
      build_frame(DEFAULT_MAC, 45);
      drive_mii_frame();
      settle();
      bus_read(reg_addr(REG_STATUS), rd);
      check_value(rd, status_word(1'b0, 1'b1, exp_next + 1'b1), "commit after credit");
      check_rx_frame(exp_next);
      finish_test("credits");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired at %0t ns before the tests finished", $time);
      $display("Test failed");
      $finish;
   end

endmodule

/* filelist.f */
src/mii_frame_pkg.sv
src/mii_frame_regs.sv
src/mii_tx_framer.sv
src/mii_rx_deframer.sv
src/mii_rx_buffers.sv
src/mii_framing_top.sv
tb/tb_mii_framing.sv
